/* host_rx_ctrl.f */
+incdir+tests
src/hctl_pkg.sv
src/tlp_reg_decoder.sv
src/host_ctrl_regs.sv
src/lbuf_dma_sched.sv
src/host_rx_ctrl_top.sv
tests/tb_host_rx_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the host rx control testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_host_rx_ctrl -f host_rx_ctrl.f --Mdir obj_dir -o vtb_host_rx_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/vtb_host_rx_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

/* tests/tlp_host_tasks.svh */
//////////////////////////////
// trn stimulus tasks
// memory-write tlps in host byte order, dma done pulse
//////////////////////////////
`ifndef TLP_HOST_TASKS_SVH
`define TLP_HOST_TASKS_SVH

// host sends payload little endian, registers hold it byte reversed
function automatic logic [31:0] to_host(input logic [31:0] dw);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
        r[8*i +: 8] = dw[8*(3-i) +: 8];
    end
    return r;
endfunction

task automatic bus_idle();
    trn_rd       = '0;
    trn_rsof_n   = 1'b1;
    trn_reof_n   = 1'b1;
    trn_rsrc_rdy = 1'b1;                 // active low, no beat
    trn_rbar_n   = 7'h7f;
    launch_mark  = 1'b0;
endtask

// one beat, held for a single clock
task automatic put_beat(input logic [63:0] d, input logic sof, input logic eof,
                        input logic [6:0] bar_n, input logic mark);
    trn_rd       = d;
    trn_rsof_n   = !sof;
    trn_reof_n   = !eof;
    trn_rsrc_rdy = 1'b0;
    trn_rbar_n   = bar_n;
    launch_mark  = mark;                 // tags the accepting edge
    @(posedge clk);
    #1;
endtask

// val is the device view, two_dw picks one or two payload dwords
task automatic send_mwr(input logic is64, input logic [6:0] fmt, input logic [6:0] bar_n,
                        input logic [5:0] off, input logic [63:0] val, input logic two_dw,
                        input logic mark);
    logic [31:0] hdr0;
    logic [31:0] hdr1;
    logic [63:0] bar_addr;
    hdr0     = {1'b0, fmt, 14'h0, two_dw ? 10'd2 : 10'd1};      // len field in dwords
    hdr1     = {16'h0100, 8'h00, two_dw ? 4'hf : 4'h0, 4'hf};   // req id, tag, byte enables
    bar_addr = BAR_BASE + {56'h0, off, 2'b00};
    put_beat({hdr0, hdr1}, 1'b1, 1'b0, bar_n, 1'b0);
    if (!is64) begin
        // 3dw header, first payload dword shares beat 2
        put_beat({bar_addr[31:0], to_host(val[31:0])}, 1'b0, !two_dw, bar_n, mark && !two_dw);
        if (two_dw) begin
            put_beat({to_host(val[63:32]), 32'h0}, 1'b0, 1'b1, bar_n, mark);
        end
    end else begin
        put_beat(bar_addr, 1'b0, 1'b0, bar_n, 1'b0);
        put_beat({to_host(val[31:0]), two_dw ? to_host(val[63:32]) : 32'h0},
                 1'b0, 1'b1, bar_n, mark);      // first dword high half
    end
    bus_idle();
endtask

// dma engine answer after lat cycles
task automatic dma_finish(input int lat, input int b);
    exp_cpl = '{addr: sb_addr[0], buf_id: (b == 2)};
    repeat (lat) @(posedge clk);
    #1;
    dma_done = 1'b1;
    @(posedge clk);
    #1;
    dma_done = 1'b0;
endtask

`endif

/* tests/tb_host_rx_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// host rx control testbench
// trn write stimulus, scoreboard, checking assertions, watchdog
//////////////////////////////

module tb_host_rx_ctrl import hctl_pkg::*; ();

    localparam int          CLK_PERIOD = 10;
    localparam int          N_TESTS    = 6;
    localparam int          TEST_CYC   = 120;       // generous per test
    localparam int          MARGIN_CYC = 200;
    localparam int          N_SERVED   = 6;         // requests and completions in the run
    localparam logic [63:0] BAR_BASE   = 64'h0000_0002_f000_0000;
    localparam logic [6:0]  BAR_OK     = 7'b111_1011;   // active-low hit on bar 2
    localparam logic [6:0]  BAR_OTHER  = 7'b111_1110;

    logic        clk;
    logic        rst;
    logic [63:0] trn_rd;
    logic        trn_rsof_n;
    logic        trn_reof_n;
    logic        trn_rsrc_rdy;          // active low
    logic [6:0]  trn_rbar_n;
    logic        dma_done;
    logic        dma_req;
    dma_desc_t   dma_desc;
    logic        cpl_req;
    cpl_desc_t   cpl_desc;

    //////////////////////////////
    // scoreboard
    logic [63:0] sb_addr [3];           // 0 cpl, 1 lbuf1, 2 lbuf2
    logic [31:0] sb_len [3];
    dma_desc_t   exp_dma;
    cpl_desc_t   exp_cpl;
    logic        dma_ok;                // a request may show up
    logic        launch_mark;           // last beat of an enable that launches at once
    int          errors = 0;
    int          n_dma = 0;
    int          n_cpl = 0;
    int unsigned seed;

    `include "tlp_host_tasks.svh"

    host_rx_ctrl_top u_dut (
        .clk              (clk),
        .rst              (rst),
        .trn_rd_i         (trn_rd),
        .trn_rsof_n_i     (trn_rsof_n),
        .trn_reof_n_i     (trn_reof_n),
        .trn_rsrc_rdy_n_i (trn_rsrc_rdy),
        .trn_rbar_hit_n_i (trn_rbar_n),
        .dma_done_i       (dma_done),
        .dma_req_o        (dma_req),
        .dma_desc_o       (dma_desc),
        .cpl_req_o        (cpl_req),
        .cpl_desc_o       (cpl_desc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (!rst && dma_req) n_dma++;
        if (!rst && cpl_req) n_cpl++;
    end

    //////////////////////////////
    // checks
    a_req_allowed: assert property (@(posedge clk) disable iff (rst) dma_req |-> dma_ok)
        else begin
            errors++;
            $display("Error: dma_req_o = %h, expected %h", $sampled(dma_req), 1'b0);
        end
    a_req_desc: assert property (@(posedge clk) disable iff (rst) dma_req |-> dma_desc == exp_dma)
        else begin
            errors++;
            $display("Error: dma_desc_o = %h, expected %h", $sampled(dma_desc), exp_dma);
        end
    // request 3 cycles after the last beat of an enable to the idle current buffer
    a_req_latency: assert property (@(posedge clk) disable iff (rst)
        $past(launch_mark, 3) |-> dma_req && !$past(dma_req) && !$past(dma_req, 2))
        else begin
            errors++;
            $display("Error: dma_req_o = %h, expected %h on the third cycle only",
                     $sampled(dma_req), 1'b1);
        end
    a_cpl_after_done: assert property (@(posedge clk) disable iff (rst)
        cpl_req == $past(dma_done))
        else begin
            errors++;
            $display("Error: cpl_req_o = %h, expected %h", $sampled(cpl_req), !$sampled(cpl_req));
        end
    a_cpl_desc: assert property (@(posedge clk) disable iff (rst) cpl_req |-> cpl_desc == exp_cpl)
        else begin
            errors++;
            $display("Error: cpl_desc_o = %h, expected %h", $sampled(cpl_desc), exp_cpl);
        end

    //////////////////////////////
    // sequencing helpers
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_for(input logic want_cpl, input int max_cyc);
        int   n;
        logic seen;
        n    = 0;
        seen = want_cpl ? cpl_req : dma_req;
        while (!seen && n < max_cyc) begin
            @(posedge clk);
            #1;
            n++;
            seen = want_cpl ? cpl_req : dma_req;
        end
        if (!seen) begin
            errors++;
            $display("%s never pulsed within %0d cycles", want_cpl ? "cpl_req_o" : "dma_req_o",
                     max_cyc);
        end
        @(posedge clk);                  // let the checks sample the pulse
        #1;
    endtask

    task automatic write_addr(input logic is64, input int idx, input logic [63:0] a);
        logic [5:0] off;
        off = (idx == 0) ? REG_CPL_ADDR : (idx == 1) ? REG_LBUF1_ADDR : REG_LBUF2_ADDR;
        sb_addr[idx] = a;
        send_mwr(is64, is64 ? FMT_MWR64 : FMT_MWR32, BAR_OK, off, a, 1'b1, 1'b0);
    endtask

    // length rides on the enable write
    task automatic write_en(input logic is64, input int b, input logic [31:0] len,
                            input logic mark);
        logic [5:0] off;
        off = (b == 1) ? REG_LBUF1_EN : REG_LBUF2_EN;
        sb_len[b] = len;
        send_mwr(is64, is64 ? FMT_MWR64 : FMT_MWR32, BAR_OK, off, {32'h0, len}, 1'b0, mark);
    endtask

    task automatic expect_dma(input int b);
        exp_dma = '{addr: sb_addr[b], len: sb_len[b], buf_id: (b == 2)};
        dma_ok  = 1'b1;
    endtask

    // request then done then completion
    // next_b of 0 means no further request
    task automatic serve(input int b, input int next_b);
        wait_for(1'b0, 20);
        if (next_b == 0) begin
            dma_ok = 1'b0;
        end else begin
            expect_dma(next_b);
        end
        dma_finish($urandom_range(8, 1), b);
        wait_for(1'b1, 4);
    endtask

    //////////////////////////////
    // stimulus
    initial begin
        seed     = $urandom(32'hb085);
        rst      = 1'b1;
        dma_done = 1'b0;
        dma_ok   = 1'b0;
        exp_dma  = '0;
        exp_cpl  = '0;
        bus_idle();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // address writes alone launch nothing after reset
        wait_cycles(10);
        write_addr(1'b0, 0, {$urandom, $urandom});
        write_addr(1'b0, 1, {$urandom, $urandom});
        wait_cycles(8);

        // 32-bit enable of lbuf1
        write_en(1'b0, 1, $urandom, 1'b1);
        expect_dma(1);
        serve(1, 0);

        // 64-bit writes to lbuf2 which is now current
        write_addr(1'b1, 2, {$urandom, $urandom});
        write_addr(1'b1, 0, {$urandom, $urandom});
        write_en(1'b1, 2, $urandom, 1'b1);
        expect_dma(2);
        serve(2, 0);

        // lbuf2 enabled first waits for lbuf1
        write_addr(1'b1, 2, {$urandom, $urandom});
        write_en(1'b1, 2, $urandom, 1'b0);
        wait_cycles(12);
        write_addr(1'b0, 1, {$urandom, $urandom});
        write_en(1'b0, 1, $urandom, 1'b1);
        expect_dma(1);
        serve(1, 2);
        serve(2, 0);

        // re-enable lbuf1 with a new length only
        write_en(1'b1, 1, $urandom, 1'b1);
        expect_dma(1);
        serve(1, 0);

        // writes to another bar or format or an unmapped offset are dropped
        send_mwr(1'b0, FMT_MWR32, BAR_OTHER, REG_LBUF2_ADDR, {$urandom, $urandom}, 1'b1, 1'b0);
        send_mwr(1'b1, FMT_MWR64, BAR_OTHER, REG_LBUF2_EN, {32'h0, $urandom}, 1'b0, 1'b0);
        send_mwr(1'b1, FMT_MWR64, BAR_OTHER, REG_CPL_ADDR, {$urandom, $urandom}, 1'b1, 1'b0);
        send_mwr(1'b0, 7'h00, BAR_OK, REG_LBUF2_EN, {32'h0, $urandom}, 1'b0, 1'b0);  // mrd32
        send_mwr(1'b1, 7'h20, BAR_OK, REG_CPL_ADDR, {$urandom, $urandom}, 1'b1, 1'b0);
        send_mwr(1'b0, FMT_MWR32, BAR_OK, 6'd10, {32'h0, $urandom}, 1'b0, 1'b0);
        send_mwr(1'b1, FMT_MWR64, BAR_OK, 6'd7, {$urandom, $urandom}, 1'b1, 1'b0);
        wait_cycles(12);
        write_en(1'b0, 2, $urandom, 1'b1);   // old lbuf2 address and cpl address expected
        expect_dma(2);
        serve(2, 0);
        wait_cycles(5);

        if (n_dma != N_SERVED || n_cpl != N_SERVED) begin
            errors++;
            $display("expected %0d dma requests and %0d completions", N_SERVED, N_SERVED);
        end
        $display("summary: %0d dma requests, %0d completions, %0d errors", n_dma, n_cpl, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((N_TESTS * TEST_CYC + MARGIN_CYC) * CLK_PERIOD);
        $display("run stopped by watchdog before the stimulus finished");
        $display("summary: %0d dma requests, %0d completions, %0d errors", n_dma, n_cpl, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src/host_rx_ctrl_top.sv */
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// host rx control top
// decoder, register file, scheduler
//////////////////////////////

module host_rx_ctrl_top import hctl_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [63:0] trn_rd_i,       // trn receive side
    input  wire logic        trn_rsof_n_i,
    input  wire logic        trn_reof_n_i,
    input  wire logic        trn_rsrc_rdy_n_i,
    input  wire logic [6:0]  trn_rbar_hit_n_i,
    input  wire logic        dma_done_i,     // from external dma engine
    output logic             dma_req_o,
    output dma_desc_t        dma_desc_o,
    output logic             cpl_req_o,
    output cpl_desc_t        cpl_desc_o
);

    reg_wr_t     reg_wr;
    logic [63:0] cpl_addr;
    lbuf_cfg_t   lbuf1;
    lbuf_cfg_t   lbuf2;
    logic        lbuf1_dn;
    logic        lbuf2_dn;

    tlp_reg_decoder u_dec (
        .clk              (clk),
        .rst              (rst),
        .trn_rd_i         (trn_rd_i),
        .trn_rsof_n_i     (trn_rsof_n_i),
        .trn_reof_n_i     (trn_reof_n_i),
        .trn_rsrc_rdy_n_i (trn_rsrc_rdy_n_i),
        .trn_rbar_hit_n_i (trn_rbar_hit_n_i),
        .reg_wr_o         (reg_wr)
    );

    host_ctrl_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .reg_wr_i   (reg_wr),
        .lbuf1_dn_i (lbuf1_dn),
        .lbuf2_dn_i (lbuf2_dn),
        .cpl_addr_o (cpl_addr),
        .lbuf1_o    (lbuf1),
        .lbuf2_o    (lbuf2)
    );

    lbuf_dma_sched u_sched (
        .clk        (clk),
        .rst        (rst),
        .lbuf1_i    (lbuf1),
        .lbuf2_i    (lbuf2),
        .cpl_addr_i (cpl_addr),
        .dma_done_i (dma_done_i),
        .lbuf1_dn_o (lbuf1_dn),
        .lbuf2_dn_o (lbuf2_dn),
        .dma_req_o  (dma_req_o),
        .dma_desc_o (dma_desc_o),
        .cpl_req_o  (cpl_req_o),
        .cpl_desc_o (cpl_desc_o)
    );

endmodule

`default_nettype wire

/* src/lbuf_dma_sched.sv */
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// ping-pong buffer scheduler
// dma descriptor out, completion notify after done
//////////////////////////////

module lbuf_dma_sched import hctl_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire lbuf_cfg_t   lbuf1_i,
    input  wire lbuf_cfg_t   lbuf2_i,
    input  wire logic [63:0] cpl_addr_i,
    input  wire logic        dma_done_i,
    output logic             lbuf1_dn_o,
    output logic             lbuf2_dn_o,
    output logic             dma_req_o,
    output dma_desc_t        dma_desc_o,
    output logic             cpl_req_o,
    output cpl_desc_t        cpl_desc_o
);

    logic [1:0] st;
    logic       cur;                 // 0 lbuf1, 1 lbuf2
    lbuf_cfg_t  cur_cfg;
    logic       launch;
    logic       finish;

    assign cur_cfg = cur ? lbuf2_i : lbuf1_i;
    assign launch  = (st == SCH_IDLE) && cur_cfg.en;
    assign finish  = (st == SCH_BUSY) && dma_done_i;

    //////////////////////////////
    // control
    always_ff @(posedge clk) begin
        if (rst) begin
            st         <= SCH_IDLE;
            cur        <= 1'b0;      // lbuf1 goes first
            dma_req_o  <= 1'b0;
            cpl_req_o  <= 1'b0;
            lbuf1_dn_o <= 1'b0;
            lbuf2_dn_o <= 1'b0;
        end else begin
            dma_req_o  <= launch;    // pulses
            cpl_req_o  <= finish;
            lbuf1_dn_o <= finish && !cur;
            lbuf2_dn_o <= finish && cur;
            case (st)
                SCH_IDLE: begin
                    if (launch) begin
                        st <= SCH_BUSY;
                    end
                end
                SCH_BUSY: begin
                    if (dma_done_i) begin
                        st  <= SCH_NOTIFY;
                        cur <= !cur;     // swap to the other buffer
                    end
                end
                SCH_NOTIFY: begin
                    st <= SCH_IDLE;      // flag of served buffer clears this cycle
                end
                default: begin
                    st <= SCH_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // descriptors, held until next launch / finish
    always_ff @(posedge clk) begin
        if (launch) begin
            dma_desc_o <= '{addr: cur_cfg.addr, len: cur_cfg.len, buf_id: cur};
        end
        if (finish) begin
            cpl_desc_o <= '{addr: cpl_addr_i, buf_id: cur};  // cur not yet toggled
        end
    end

    // dma engine only answers an outstanding descriptor
    a_done_when_busy: assert property (@(posedge clk) disable iff (rst)
        dma_done_i |-> (st == SCH_BUSY));

endmodule

`default_nettype wire

/* src/host_ctrl_regs.sv */
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// bar register file
// completion address, buffer addresses, lengths, enables
//////////////////////////////

module host_ctrl_regs import hctl_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire reg_wr_t   reg_wr_i,
    input  wire logic      lbuf1_dn_i,
    input  wire logic      lbuf2_dn_i,
    output logic [63:0]    cpl_addr_o,
    output lbuf_cfg_t      lbuf1_o,
    output lbuf_cfg_t      lbuf2_o
);

    logic [63:0] cpl_addr_q;
    logic [63:0] lbuf1_addr_q;
    logic [31:0] lbuf1_len_q;
    logic        lbuf1_en_q;
    logic [63:0] lbuf2_addr_q;
    logic [31:0] lbuf2_len_q;
    logic        lbuf2_en_q;
    logic        wr_en1;
    logic        wr_en2;

    assign wr_en1 = reg_wr_i.valid && (reg_wr_i.offset == REG_LBUF1_EN);
    assign wr_en2 = reg_wr_i.valid && (reg_wr_i.offset == REG_LBUF2_EN);

    //////////////////////////////
    // enable flags
    always_ff @(posedge clk) begin
        if (rst) begin
            lbuf1_en_q <= 1'b0;
            lbuf2_en_q <= 1'b0;
        end else begin
            if (wr_en1) begin
                lbuf1_en_q <= 1'b1;
            end else if (lbuf1_dn_i) begin
                lbuf1_en_q <= 1'b0;         // buffer consumed
            end
            if (wr_en2) begin
                lbuf2_en_q <= 1'b1;
            end else if (lbuf2_dn_i) begin
                lbuf2_en_q <= 1'b0;
            end
        end
    end

    // address and length values
    always_ff @(posedge clk) begin
        if (reg_wr_i.valid) begin
            case (reg_wr_i.offset)
                REG_CPL_ADDR:   cpl_addr_q   <= reg_wr_i.data;
                REG_LBUF1_ADDR: lbuf1_addr_q <= reg_wr_i.data;
                REG_LBUF1_EN:   lbuf1_len_q  <= reg_wr_i.data[31:0];  // len rides on enable
                REG_LBUF2_ADDR: lbuf2_addr_q <= reg_wr_i.data;
                REG_LBUF2_EN:   lbuf2_len_q  <= reg_wr_i.data[31:0];
                default: ;
            endcase
        end
    end

    assign cpl_addr_o = cpl_addr_q;
    assign lbuf1_o    = '{addr: lbuf1_addr_q, len: lbuf1_len_q, en: lbuf1_en_q};
    assign lbuf2_o    = '{addr: lbuf2_addr_q, len: lbuf2_len_q, en: lbuf2_en_q};

    // scheduler only finishes buffers that were handed to it
    a_dn1_while_en: assert property (@(posedge clk) disable iff (rst)
        lbuf1_dn_i |-> lbuf1_en_q);
    a_dn2_while_en: assert property (@(posedge clk) disable iff (rst)
        lbuf2_dn_i |-> lbuf2_en_q);

endmodule

`default_nettype wire

/* src/tlp_reg_decoder.sv */
`timescale 1ns/1ns
`default_nettype none
//////////////////////////////
// trn receive decoder
// memory-write tlps hitting the bar become register strobes
//////////////////////////////

module tlp_reg_decoder import hctl_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [63:0] trn_rd_i,
    input  wire logic        trn_rsof_n_i,
    input  wire logic        trn_reof_n_i,
    input  wire logic        trn_rsrc_rdy_n_i,
    input  wire logic [6:0]  trn_rbar_hit_n_i,
    output reg_wr_t          reg_wr_o
);

    logic [DEC_NST-1:0] st;              // one-hot
    logic [DEC_NST-1:0] st_nxt;
    tlp_qw1_u           qw1;             // beat 2 seen through either header view
    logic               beat;
    logic [6:0]         fmt;
    logic [5:0]         off32;
    logic [5:0]         off64;
    logic [31:0]        dw0_q;           // first payload dword, 3dw header only
    logic [5:0]         off_q;           // offset held for beat 3
    logic               wr_go;
    logic [5:0]         wr_off;
    logic [63:0]        wr_data;
    logic               wr_vld_q;
    logic [5:0]         wr_off_q;
    logic [63:0]        wr_data_q;

    function automatic logic [DEC_NST-1:0] one_st(input int idx);
        return DEC_NST'(1) << idx;
    endfunction

    function automatic logic is_addr_reg(input logic [5:0] off);
        return (off == REG_CPL_ADDR) || (off == REG_LBUF1_ADDR) || (off == REG_LBUF2_ADDR);
    endfunction

    function automatic logic is_en_reg(input logic [5:0] off);
        return (off == REG_LBUF1_EN) || (off == REG_LBUF2_EN);
    endfunction

    assign beat  = !trn_rsrc_rdy_n_i;       // source never throttled, rdy marks a beat
    assign fmt   = trn_rd_i[62:56];         // fmt + type of header dw0
    assign qw1   = trn_rd_i;
    assign off32 = qw1.hdr32.addr[7:2];
    assign off64 = qw1.hdr64.addr_lo[7:2];

    //////////////////////////////
    // next state and strobe payload
    always_comb begin
        st_nxt  = st;
        wr_go   = 1'b0;
        wr_off  = off_q;
        wr_data = {dw_swap(trn_rd_i[31:0]), dw_swap(trn_rd_i[63:32])};  // 4dw data beat
        if (beat) begin
            st_nxt = one_st(DEC_IDLE);      // most beats end the walk
            case (1'b1)
                st[DEC_IDLE]: begin
                    // header beat of a write is never the last beat
                    if (!trn_rsof_n_i && trn_reof_n_i && !trn_rbar_hit_n_i[TRN_BAR_HIT]) begin
                        if (fmt == FMT_MWR32) begin
                            st_nxt = one_st(DEC_HDR32);
                        end else if (fmt == FMT_MWR64) begin
                            st_nxt = one_st(DEC_HDR64);
                        end
                    end
                end
                st[DEC_HDR32]: begin
                    if (is_en_reg(off32)) begin   // length fits in beat 2
                        wr_go   = 1'b1;
                        wr_off  = off32;
                        wr_data = {32'h0, dw_swap(qw1.hdr32.dw0)};
                    end else if (is_addr_reg(off32) && trn_reof_n_i) begin
                        st_nxt = one_st(DEC_DATA32);
                    end
                end
                st[DEC_HDR64]: begin
                    if ((is_en_reg(off64) || is_addr_reg(off64)) && trn_reof_n_i) begin
                        st_nxt = one_st(DEC_DATA64);
                    end
                end
                st[DEC_DATA32]: begin
                    wr_go   = 1'b1;
                    wr_data = {dw_swap(trn_rd_i[63:32]), dw_swap(dw0_q)};
                end
                st[DEC_DATA64]: begin
                    wr_go = 1'b1;                 // first dword sits in the high half
                end
                default: begin
                    st_nxt = one_st(DEC_IDLE);
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st       <= one_st(DEC_IDLE);
            wr_vld_q <= 1'b0;
        end else begin
            st       <= st_nxt;
            wr_vld_q <= wr_go;              // single cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        if (beat && st[DEC_HDR32]) begin
            dw0_q <= qw1.hdr32.dw0;
        end
        if (beat && (st[DEC_HDR32] || st[DEC_HDR64])) begin
            off_q <= st[DEC_HDR64] ? off64 : off32;
        end
        if (wr_go) begin
            wr_off_q  <= wr_off;
            wr_data_q <= wr_data;
        end
    end

    assign reg_wr_o = '{valid: wr_vld_q, offset: wr_off_q, data: wr_data_q};

    // a new frame must not start while a write is still being walked
    a_no_sof_mid_tlp: assert property (@(posedge clk) disable iff (rst)
        (!st[DEC_IDLE] && beat) |-> trn_rsof_n_i);

endmodule

`default_nettype wire

/* src/hctl_pkg.sv */
`default_nettype none
//////////////////////////////
// shared host control definitions
// bar register map, tlp format codes, fsm encodings
// strobe and descriptor structs, beat 2 union, dword swap
//////////////////////////////

package hctl_pkg;

    //////////////////////////////
    // trn and bar map
    localparam int TRN_BAR_HIT = 2;          // bit in active-low bar hit vector

    localparam logic [5:0] REG_CPL_ADDR   = 6'd0;   // dword offsets in bar
    localparam logic [5:0] REG_LBUF1_ADDR = 6'd2;
    localparam logic [5:0] REG_LBUF1_EN   = 6'd4;
    localparam logic [5:0] REG_LBUF2_ADDR = 6'd6;
    localparam logic [5:0] REG_LBUF2_EN   = 6'd8;

    localparam logic [6:0] FMT_MWR32 = 7'b100_0000;  // 3dw header with data
    localparam logic [6:0] FMT_MWR64 = 7'b110_0000;  // 4dw header with data

    //////////////////////////////
    // fsm encodings
    localparam int DEC_NST    = 5;           // decoder is one-hot, these are bit indices
    localparam int DEC_IDLE   = 0;
    localparam int DEC_HDR32  = 1;           // waiting for beat 2, 3dw header
    localparam int DEC_HDR64  = 2;           // waiting for beat 2, 4dw header
    localparam int DEC_DATA32 = 3;           // beat 3, second payload dword
    localparam int DEC_DATA64 = 4;           // beat 3, both payload dwords

    localparam logic [1:0] SCH_IDLE   = 2'd0;
    localparam logic [1:0] SCH_BUSY   = 2'd1;
    localparam logic [1:0] SCH_NOTIFY = 2'd2;

    //////////////////////////////
    // types
    typedef union packed {
        struct packed {
            logic [31:0] addr;               // dw2 of the 3dw header
            logic [31:0] dw0;                // first payload dword
        } hdr32;
        struct packed {
            logic [31:0] addr_hi;
            logic [31:0] addr_lo;
        } hdr64;
    } tlp_qw1_u;

    typedef struct packed {
        logic        valid;
        logic [5:0]  offset;
        logic [63:0] data;                   // payload already in device byte order
    } reg_wr_t;

    typedef struct packed {
        logic [63:0] addr;
        logic [31:0] len;
        logic        buf_id;                 // 0 lbuf1, 1 lbuf2
    } dma_desc_t;

    typedef struct packed {
        logic [63:0] addr;
        logic        buf_id;
    } cpl_desc_t;

    typedef struct packed {
        logic [63:0] addr;
        logic [31:0] len;
        logic        en;
    } lbuf_cfg_t;

    // host byte order to device byte order
    function automatic logic [31:0] dw_swap(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

endpackage

`default_nettype wire
